// File: Makefile
TOP := tb_pipeline_core
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)
	verilator --lint-only --assert hw/mips_pkg.sv hw/register_file.sv hw/decode_unit.sv \
		hw/id_ex.sv hw/execute_unit.sv hw/ex_mem.sv hw/pipeline_core.sv \
		--top-module pipeline_core

sim:
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: hw/decode_unit.sv
`timescale 1ns/1ps

module decode_unit
    import mips_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic [NB-1:0]      i_instruction,
    input  logic [NB-1:0]      i_pc4,
    input  logic               i_wb_write,
    input  logic [NB_REGS-1:0] i_wb_addr,
    input  logic [NB-1:0]      i_wb_data,
    output id_ex_t             o_id_ex
);

    opcode_e             opcode;
    logic [NB_FCODE-1:0] funct;
    logic [NB_REGS-1:0]  rs;
    logic [NB_REGS-1:0]  rt;
    logic [NB_REGS-1:0]  rd;
    logic [4:0]          shamt;
    logic [15:0]         imm;
    logic [25:0]         target;
    logic                zero_ext;
    logic [NB-1:0]       rs_data;
    logic [NB-1:0]       rt_data;

    assign opcode = opcode_e'(i_instruction[31:26]);
    assign rs     = i_instruction[25:21];
    assign rt     = i_instruction[20:16];
    assign rd     = i_instruction[15:11];
    assign shamt  = i_instruction[10:6];
    assign funct  = i_instruction[5:0];
    assign imm    = i_instruction[15:0];
    assign target = i_instruction[25:0];

    // Logical immediates take zero extension.
    assign zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);

    register_file u_register_file (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_rs_addr (rs),
        .i_rt_addr (rt),
        .i_wr_en   (i_wb_write),
        .i_wr_addr (i_wb_addr),
        .i_wr_data (i_wb_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    always_comb begin
        o_id_ex                  = '0;
        o_id_ex.opcode           = opcode;
        o_id_ex.funct            = funct;
        o_id_ex.data_a           = rs_data;
        o_id_ex.data_b           = rt_data;
        o_id_ex.shamt            = {{(NB-5){1'b0}}, shamt};
        o_id_ex.extension_result = zero_ext ? {16'b0, imm} : {{16{imm[15]}}, imm};
        o_id_ex.pc4              = i_pc4;
        o_id_ex.word_size        = WS_WORD;
        o_id_ex.reg_dir_to_write = rt;
        o_id_ex.jump_addr        = {i_pc4[31:28], target, 2'b00};

        case (opcode)
            OP_RTYPE: begin
                o_id_ex.reg_dir_to_write = rd;
                case (funct)
                    FN_SLL, FN_SRL, FN_SRA, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                    FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU: o_id_ex.reg_write = 1'b1;
                    default: o_id_ex = '0;              // Unsupported funct, bubble.
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                o_id_ex.alu_src   = 1'b1;
                o_id_ex.reg_write = 1'b1;
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                o_id_ex.alu_src    = 1'b1;
                o_id_ex.mem_read   = 1'b1;
                o_id_ex.mem_to_reg = 1'b1;
                o_id_ex.reg_write  = 1'b1;
                o_id_ex.is_signed  = (opcode == OP_LB) || (opcode == OP_LH) || (opcode == OP_LW);
                if (opcode == OP_LB || opcode == OP_LBU) begin
                    o_id_ex.word_size = WS_BYTE;
                end else if (opcode == OP_LH || opcode == OP_LHU) begin
                    o_id_ex.word_size = WS_HALF;
                end
            end
            OP_SB, OP_SH, OP_SW: begin
                o_id_ex.alu_src   = 1'b1;
                o_id_ex.mem_write = 1'b1;
                if (opcode == OP_SB) begin
                    o_id_ex.word_size = WS_BYTE;
                end else if (opcode == OP_SH) begin
                    o_id_ex.word_size = WS_HALF;
                end
            end
            OP_BEQ, OP_BNE: o_id_ex.branch = 1'b1;
            OP_J: o_id_ex.jump = 1'b1;
            OP_JAL: begin
                o_id_ex.jump             = 1'b1;
                o_id_ex.link             = 1'b1;
                o_id_ex.reg_write        = 1'b1;
                o_id_ex.reg_dir_to_write = {NB_REGS{1'b1}}; // Link register r31.
            end
            default: o_id_ex = '0;
        endcase
    end

endmodule

// File: hw/ex_mem.sv
`timescale 1ns/1ps

module ex_mem
    import mips_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset,
    input  logic    i_step,
    input  ex_mem_t i_ex_mem,
    output ex_mem_t o_ex_mem
);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ex_mem <= '0;
        end else if (i_step) begin
            o_ex_mem <= i_ex_mem;                   // Holds while stepping is off.
        end
    end

    // Decode never asks for a read and a write together.
    a_rd_wr_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_ex_mem.mem_read && o_ex_mem.mem_write))
        else $error("ex_mem: mem_read and mem_write both set");

endmodule

// File: hw/execute_unit.sv
`timescale 1ns/1ps

module execute_unit
    import mips_pkg::*;
(
    input  id_ex_t  i_id_ex,
    output ex_mem_t o_ex_mem
);

    alu_op_e       alu_op;
    logic          shift_const;
    logic [NB-1:0] operand_a;
    logic [NB-1:0] operand_b;
    logic [NB-1:0] alu_result;
    logic [NB-1:0] branch_target;
    logic          taken;
    logic          redirect;

    always_comb begin
        alu_op      = ALU_ADD;                  // Loads, stores, ADDI, jumps.
        shift_const = 1'b0;
        case (i_id_ex.opcode)
            OP_RTYPE: begin
                case (i_id_ex.funct)
                    FN_SUB, FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:          alu_op = ALU_AND;
                    FN_OR:           alu_op = ALU_OR;
                    FN_XOR:          alu_op = ALU_XOR;
                    FN_NOR:          alu_op = ALU_NOR;
                    FN_SLT:          alu_op = ALU_SLT;
                    FN_SLTU:         alu_op = ALU_SLTU;
                    FN_SLL:          alu_op = ALU_SLL;
                    FN_SRL:          alu_op = ALU_SRL;
                    FN_SRA:          alu_op = ALU_SRA;
                    default:         alu_op = ALU_ADD;
                endcase
                shift_const = (i_id_ex.funct == FN_SLL) || (i_id_ex.funct == FN_SRL) ||
                              (i_id_ex.funct == FN_SRA);
            end
            OP_SLTI:        alu_op = ALU_SLT;
            OP_SLTIU:       alu_op = ALU_SLTU;
            OP_ANDI:        alu_op = ALU_AND;
            OP_ORI:         alu_op = ALU_OR;
            OP_XORI:        alu_op = ALU_XOR;
            OP_LUI:         alu_op = ALU_LUI;
            OP_BEQ, OP_BNE: alu_op = ALU_SUB;
            default:        alu_op = ALU_ADD;
        endcase
    end

    // Constant shifts work on rt by shamt.
    assign operand_a = shift_const ? i_id_ex.data_b : i_id_ex.data_a;
    assign operand_b = shift_const ? i_id_ex.shamt :
                       (i_id_ex.alu_src ? i_id_ex.extension_result : i_id_ex.data_b);

    always_comb begin
        case (alu_op)
            ALU_SUB:  alu_result = operand_a - operand_b;
            ALU_AND:  alu_result = operand_a & operand_b;
            ALU_OR:   alu_result = operand_a | operand_b;
            ALU_XOR:  alu_result = operand_a ^ operand_b;
            ALU_NOR:  alu_result = ~(operand_a | operand_b);
            ALU_SLT:  alu_result = {{(NB-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            ALU_SLTU: alu_result = {{(NB-1){1'b0}}, operand_a < operand_b};
            ALU_SLL:  alu_result = operand_a << operand_b[4:0];
            ALU_SRL:  alu_result = operand_a >> operand_b[4:0];
            ALU_SRA:  alu_result = $signed(operand_a) >>> operand_b[4:0];
            ALU_LUI:  alu_result = {operand_b[15:0], 16'b0};
            default:  alu_result = operand_a + operand_b;
        endcase
    end

    assign taken = i_id_ex.branch &&
                   ((i_id_ex.opcode == OP_BEQ) ? (i_id_ex.data_a == i_id_ex.data_b)
                                               : (i_id_ex.data_a != i_id_ex.data_b));
    assign branch_target = i_id_ex.pc4 + {i_id_ex.extension_result[NB-3:0], 2'b00};
    assign redirect      = taken || i_id_ex.jump;

    always_comb begin
        o_ex_mem                  = '0;
        o_ex_mem.result           = i_id_ex.link ? i_id_ex.pc4 : alu_result;
        o_ex_mem.store_data       = i_id_ex.data_b;
        o_ex_mem.word_size        = i_id_ex.word_size;
        o_ex_mem.is_signed        = i_id_ex.is_signed;
        o_ex_mem.mem_read         = i_id_ex.mem_read;
        o_ex_mem.mem_write        = i_id_ex.mem_write;
        o_ex_mem.mem_to_reg       = i_id_ex.mem_to_reg;
        o_ex_mem.reg_write        = i_id_ex.reg_write;
        o_ex_mem.reg_dir_to_write = i_id_ex.reg_dir_to_write;
        o_ex_mem.pc_redirect      = redirect;
        // Sequential PC when nothing redirects.
        if (i_id_ex.jump) begin
            o_ex_mem.next_pc = i_id_ex.jump_addr;
        end else if (taken) begin
            o_ex_mem.next_pc = branch_target;
        end else begin
            o_ex_mem.next_pc = i_id_ex.pc4;
        end
    end

endmodule

// File: hw/id_ex.sv
`timescale 1ns/1ps

module id_ex
    import mips_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_reset,
    input  logic   i_step,
    input  id_ex_t i_id_ex,
    output id_ex_t o_id_ex
);

    logic quiet;

    // All-zero contents are a bubble.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_id_ex <= '0;
        end else if (i_step) begin
            o_id_ex <= i_id_ex;
        end
    end

    assign quiet = !o_id_ex.reg_write && !o_id_ex.mem_write;

    // Once out of reset the stage stays quiet until a step loads it.
    a_bubble_until_step: assert property (@(posedge i_clk) disable iff (i_reset)
        ($past(i_reset) || (!$past(i_step) && $past(quiet))) |-> quiet)
        else $error("id_ex: side effect appeared without a step");

endmodule

// File: hw/mips_pkg.sv
package mips_pkg;

    localparam int NB        = 32;
    localparam int NB_REGS   = 5;
    localparam int NB_OPCODE = 6;
    localparam int NB_FCODE  = 6;
    localparam int NUM_REGS  = 2 ** NB_REGS;

    typedef enum logic [NB_OPCODE-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_SLTIU = 6'h0b,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LB    = 6'h20,
        OP_LH    = 6'h21,
        OP_LW    = 6'h23,
        OP_LBU   = 6'h24,
        OP_LHU   = 6'h25,
        OP_SB    = 6'h28,
        OP_SH    = 6'h29,
        OP_SW    = 6'h2b
    } opcode_e;

    // Constant shifts only, no variable shift forms.
    typedef enum logic [NB_FCODE-1:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        WS_BYTE = 3'b001,
        WS_HALF = 3'b010,
        WS_WORD = 3'b100
    } word_size_e;

    typedef struct packed {
        opcode_e              opcode;
        logic [NB_FCODE-1:0]  funct;
        logic                 alu_src;          // 0 data_b, 1 immediate.
        logic                 is_signed;        // Sign-extend loaded data.
        logic [NB-1:0]        data_a;
        logic [NB-1:0]        data_b;
        logic [NB-1:0]        shamt;
        logic [NB-1:0]        extension_result;
        logic [NB-1:0]        pc4;
        logic                 branch;
        word_size_e           word_size;
        logic                 mem_read;
        logic                 mem_write;
        logic                 mem_to_reg;
        logic                 reg_write;
        logic [NB_REGS-1:0]   reg_dir_to_write;
        logic                 jump;
        logic [NB-1:0]        jump_addr;
        logic                 link;             // JAL writes PC+4.
    } id_ex_t;

    typedef struct packed {
        logic [NB-1:0]        result;           // Address for loads and stores.
        logic [NB-1:0]        store_data;
        word_size_e           word_size;
        logic                 is_signed;
        logic                 mem_read;
        logic                 mem_write;
        logic                 mem_to_reg;
        logic                 reg_write;
        logic [NB_REGS-1:0]   reg_dir_to_write;
        logic                 pc_redirect;
        logic [NB-1:0]        next_pc;
    } ex_mem_t;

endpackage

// File: hw/pipeline_core.sv
`timescale 1ns/1ps

module pipeline_core
    import mips_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_step,
    input  logic [NB-1:0]      i_instruction,
    input  logic [NB-1:0]      i_pc4,
    input  logic               i_wb_write,
    input  logic [NB_REGS-1:0] i_wb_addr,
    input  logic [NB-1:0]      i_wb_data,
    output ex_mem_t            o_ex_mem
);

    id_ex_t  decoded;
    id_ex_t  id_ex_q;
    ex_mem_t executed;

    decode_unit u_decode_unit (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_instruction (i_instruction),
        .i_pc4         (i_pc4),
        .i_wb_write    (i_wb_write),
        .i_wb_addr     (i_wb_addr),
        .i_wb_data     (i_wb_data),
        .o_id_ex       (decoded)
    );

    id_ex u_id_ex (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_step  (i_step),
        .i_id_ex (decoded),
        .o_id_ex (id_ex_q)
    );

    execute_unit u_execute_unit (
        .i_id_ex  (id_ex_q),
        .o_ex_mem (executed)
    );

    ex_mem u_ex_mem (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_step   (i_step),
        .i_ex_mem (executed),
        .o_ex_mem (o_ex_mem)
    );

endmodule

// File: hw/register_file.sv
`timescale 1ns/1ps

module register_file
    import mips_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic [NB_REGS-1:0] i_rs_addr,
    input  logic [NB_REGS-1:0] i_rt_addr,
    input  logic               i_wr_en,
    input  logic [NB_REGS-1:0] i_wr_addr,
    input  logic [NB-1:0]      i_wr_data,
    output logic [NB-1:0]      o_rs_data,
    output logic [NB-1:0]      o_rt_data
);

    logic [NB-1:0] regs [NUM_REGS];

    // r0 is cleared on reset and never written, so it stays zero.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // A write lands after the edge, so same-cycle reads see the old value.
    assign o_rs_data = regs[i_rs_addr];
    assign o_rt_data = regs[i_rt_addr];

    a_rs_zero: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_rs_addr == '0) |-> (o_rs_data == '0))
        else $error("register_file: rs read of r0 is not zero");

    a_rt_zero: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_rt_addr == '0) |-> (o_rt_data == '0))
        else $error("register_file: rt read of r0 is not zero");

endmodule

// File: list.f
hw/mips_pkg.sv
hw/register_file.sv
hw/decode_unit.sv
hw/id_ex.sv
hw/execute_unit.sv
hw/ex_mem.sv
hw/pipeline_core.sv
verification/tb_pipeline_core.sv

// File: verification/tb_pipeline_core.sv
`timescale 1ns/1ps

module tb_pipeline_core
    import mips_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int N_RTYPE      = 300;
    localparam int N_IMM        = 240;
    localparam int N_MEM        = 160;
    localparam int N_BRANCH     = 160;
    localparam int N_STALL      = 100;
    localparam int MAX_GAP      = 4;
    // Twice the longest possible run, with every stall at its maximum.
    localparam int MAX_CYCLES   = 2 * (RESET_CYCLES + 40 + N_RTYPE + N_IMM + N_MEM + N_BRANCH
                                       + N_STALL * (MAX_GAP + 1) + 10);

    logic               clk = 1'b0;
    logic               reset;
    logic               step;
    logic [NB-1:0]      instruction;
    logic [NB-1:0]      pc4;
    logic               wb_write;
    logic [NB_REGS-1:0] wb_addr;
    logic [NB-1:0]      wb_data;
    ex_mem_t            core_out;

    logic [NB-1:0]      reg_model [NUM_REGS];
    ex_mem_t            exp_q [$];
    ex_mem_t            exp_now;
    ex_mem_t            held = '0;
    logic               stepped = 1'b0;
    logic               running = 1'b0;
    logic [NB-1:0]      pc;
    int                 cycles = 0;
    int                 data_errors = 0;
    int                 ctrl_errors = 0;
    int                 hold_errors = 0;
    int                 other_errors = 0;

    funct_e  rtype_fn [13] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR,
                               FN_NOR, FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
    opcode_e imm_ops [8]   = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                               OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    opcode_e mem_ops [8]   = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};

    pipeline_core dut (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_step        (step),
        .i_instruction (instruction),
        .i_pc4         (pc4),
        .i_wb_write    (wb_write),
        .i_wb_addr     (wb_addr),
        .i_wb_data     (wb_data),
        .o_ex_mem      (core_out)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        stepped <= step && !reset;
        cycles  <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic word_size_e size_of(input opcode_e op);
        if (op == OP_LB || op == OP_LBU || op == OP_SB) begin
            return WS_BYTE;
        end else if (op == OP_LH || op == OP_LHU || op == OP_SH) begin
            return WS_HALF;
        end
        return WS_WORD;
    endfunction

    function automatic ex_mem_t expected_ex_mem(input logic [NB-1:0] instr,
                                                input logic [NB-1:0] pc4_in);
        ex_mem_t       e;
        opcode_e       op;
        logic [NB-1:0] a;
        logic [NB-1:0] b;
        logic [NB-1:0] sext;
        logic [NB-1:0] zext;
        logic [4:0]    sh;
        op   = opcode_e'(instr[31:26]);
        a    = reg_model[instr[25:21]];
        b    = reg_model[instr[20:16]];
        sh   = instr[10:6];
        sext = {{16{instr[15]}}, instr[15:0]};
        zext = {16'b0, instr[15:0]};
        e                  = '0;
        e.store_data       = b;
        e.word_size        = size_of(op);
        e.next_pc          = pc4_in;             // Sequential unless redirected.
        e.reg_dir_to_write = instr[20:16];
        case (op)
            OP_RTYPE: begin
                e.reg_write        = 1'b1;
                e.reg_dir_to_write = instr[15:11];
                case (funct_e'(instr[5:0]))
                    FN_ADD, FN_ADDU: e.result = a + b;
                    FN_SUB, FN_SUBU: e.result = a - b;
                    FN_AND:  e.result = a & b;
                    FN_OR:   e.result = a | b;
                    FN_XOR:  e.result = a ^ b;
                    FN_NOR:  e.result = ~(a | b);
                    FN_SLT:  e.result = {31'b0, $signed(a) < $signed(b)};
                    FN_SLTU: e.result = {31'b0, a < b};
                    FN_SLL:  e.result = b << sh;
                    FN_SRL:  e.result = b >> sh;
                    FN_SRA:  e.result = $signed(b) >>> sh;
                    default: e = '0;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                e.reg_write = 1'b1;
                case (op)
                    OP_SLTI:  e.result = {31'b0, $signed(a) < $signed(sext)};
                    OP_SLTIU: e.result = {31'b0, a < sext};
                    OP_ANDI:  e.result = a & zext;
                    OP_ORI:   e.result = a | zext;
                    OP_XORI:  e.result = a ^ zext;
                    OP_LUI:   e.result = {instr[15:0], 16'b0};
                    default:  e.result = a + sext;
                endcase
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                e.result     = a + sext;
                e.mem_read   = 1'b1;
                e.mem_to_reg = 1'b1;
                e.reg_write  = 1'b1;
                e.is_signed  = (op == OP_LB) || (op == OP_LH) || (op == OP_LW);
            end
            OP_SB, OP_SH, OP_SW: begin
                e.result    = a + sext;
                e.mem_write = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                if ((op == OP_BEQ) == (a == b)) begin
                    e.pc_redirect = 1'b1;
                    e.next_pc     = pc4_in + {sext[29:0], 2'b00};
                end
            end
            OP_J, OP_JAL: begin
                e.pc_redirect = 1'b1;
                e.next_pc     = {pc4_in[31:28], instr[25:0], 2'b00};
                if (op == OP_JAL) begin
                    e.reg_write        = 1'b1;
                    e.reg_dir_to_write = 5'd31;
                    e.result           = pc4_in;
                end
            end
            default: e = '0;
        endcase
        return e;
    endfunction

    task automatic compare_field(input string field, input logic [NB-1:0] got,
                                 input logic [NB-1:0] exp, inout int errs);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, field, got, exp);
            errs++;
        end
    endtask

    task automatic check_data(input ex_mem_t got, input ex_mem_t exp);
        if (exp.reg_write || exp.mem_read || exp.mem_write) begin
            compare_field("result", got.result, exp.result, data_errors);
        end
        if (exp.mem_write) begin
            compare_field("store_data", got.store_data, exp.store_data, data_errors);
        end
        compare_field("next_pc", got.next_pc, exp.next_pc, data_errors);
    endtask

    task automatic check_control(input ex_mem_t got, input ex_mem_t exp);
        compare_field("mem_read", NB'(got.mem_read), NB'(exp.mem_read), ctrl_errors);
        compare_field("mem_write", NB'(got.mem_write), NB'(exp.mem_write), ctrl_errors);
        compare_field("mem_to_reg", NB'(got.mem_to_reg), NB'(exp.mem_to_reg), ctrl_errors);
        compare_field("reg_write", NB'(got.reg_write), NB'(exp.reg_write), ctrl_errors);
        compare_field("pc_redirect", NB'(got.pc_redirect), NB'(exp.pc_redirect), ctrl_errors);
        compare_field("is_signed", NB'(got.is_signed), NB'(exp.is_signed), ctrl_errors);
        if (exp.mem_read || exp.mem_write) begin
            compare_field("word_size", NB'(got.word_size), NB'(exp.word_size), ctrl_errors);
        end
        if (exp.reg_write) begin
            compare_field("reg_dir_to_write", NB'(got.reg_dir_to_write),
                          NB'(exp.reg_dir_to_write), ctrl_errors);
        end
    endtask

    // Output is registered, so it is stable at the falling edge.
    always @(negedge clk) begin
        if (running) begin
            if (stepped) begin
                if (exp_q.size() == 0) begin
                    $display("A step completed with no expected result queued.");
                    other_errors++;
                end else begin
                    exp_now = exp_q.pop_front();
                    check_data(core_out, exp_now);
                    check_control(core_out, exp_now);
                end
            end else if (core_out !== held) begin
                $display("ERR %0t: o_ex_mem changed while stepping was off", $time);
                hold_errors++;
            end
            held = core_out;
        end
    end

    function automatic logic [NB_REGS-1:0] rand_reg();
        logic [NB-1:0] r;
        r = $urandom;
        return (r[31:30] == 2'b00) ? '0 : r[4:0];     // r0 about one time in four.
    endfunction

    function automatic logic [15:0] rand_half();
        logic [NB-1:0] r;
        r = $urandom;
        return r[15:0];
    endfunction

    function automatic logic [NB-1:0] rand_flow();
        logic [NB-1:0]      r;
        logic [NB_REGS-1:0] rs;
        logic [NB_REGS-1:0] rt;
        r  = $urandom;
        rs = rand_reg();
        rt = r[0] ? rs : rand_reg();                 // Equal operands half the time.
        case (r[2:1])
            2'd0:    return {OP_BEQ, rs, rt, r[31:16]};
            2'd1:    return {OP_BNE, rs, rt, r[31:16]};
            2'd2:    return {OP_J, r[31:6]};
            default: return {OP_JAL, r[31:6]};
        endcase
    endfunction

    function automatic logic [NB-1:0] rand_instr(input int kind);
        case (kind)
            0:       return {6'h00, rand_reg(), rand_reg(), rand_reg(), 5'($urandom_range(31)),
                             rtype_fn[$urandom_range(12)]};
            1:       return {imm_ops[$urandom_range(7)], rand_reg(), rand_reg(), rand_half()};
            2:       return {mem_ops[$urandom_range(7)], rand_reg(), rand_reg(), rand_half()};
            default: return rand_flow();
        endcase
    endfunction

    task automatic issue(input logic [NB-1:0] instr, input int gap);
        @(negedge clk);
        instruction = instr;
        pc4         = pc;
        step        = 1'b1;
        exp_q.push_back(expected_ex_mem(instr, pc));
        pc = pc + 4;
        repeat (gap) begin
            @(negedge clk);
            step        = 1'b0;
            instruction = $urandom;                  // Junk while the stages hold.
        end
    endtask

    initial begin
        void'($urandom(32'hf4f54636));
        reset       = 1'b1;
        step        = 1'b0;
        instruction = '0;
        pc4         = '0;
        wb_write    = 1'b0;
        wb_addr     = '0;
        wb_data     = '0;
        pc          = $urandom;
        pc[1:0]     = 2'b00;
        for (int r = 0; r < NUM_REGS; r++) begin
            reg_model[r] = '0;
        end
        exp_q.push_back('0);                         // Bubble held by ID/EX after reset.
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (core_out !== '0) begin
            $display("ERR %0t: o_ex_mem is not all zero after reset", $time);
            other_errors++;
        end
        // The write to r0 must be dropped.
        for (int r = 0; r < NUM_REGS; r++) begin
            @(negedge clk);
            wb_write = 1'b1;
            wb_addr  = r[4:0];
            wb_data  = $urandom;
            if (r != 0) begin
                reg_model[r] = wb_data;
            end
        end
        @(negedge clk);
        wb_write = 1'b0;
        running  = 1'b1;
        repeat (N_RTYPE) issue(rand_instr(0), 0);
        repeat (N_IMM) issue(rand_instr(1), 0);
        repeat (N_MEM) issue(rand_instr(2), 0);
        repeat (N_BRANCH) issue(rand_instr(3), 0);
        repeat (N_STALL) issue(rand_instr($urandom_range(3)), $urandom_range(MAX_GAP));
        repeat (2) issue('0, 0);                     // Flush the last instruction out.
        @(negedge clk);
        step = 1'b0;
        repeat (3) @(negedge clk);
        if (exp_q.size() != 1) begin
            $display("Not every issued instruction reached the output.");
            other_errors++;
        end
        $display("Errors: data %0d, control %0d, hold %0d, other %0d",
                 data_errors, ctrl_errors, hold_errors, other_errors);
        if (data_errors + ctrl_errors + hold_errors + other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
